//--- all.f
hdl/pga_pkg.sv
hdl/gain_op_if.sv
hdl/pga_cmd_decode.sv
hdl/pga_gain_exec.sv
hdl/pga_spi_writer.sv
hdl/pga_ctrl_top.sv
dv/pga_ctrl_chk.sv
dv/pga_ctrl_tb.sv

//--- Makefile
# Verilator build and run for the PGA gain controller testbench.

VERILATOR ?= verilator
TOP       ?= pga_ctrl_tb
SEED      ?= 94751
LOG       ?= sim.log
FLIST     ?= all.f

SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary --assert --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	-./$(BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "All tests passed" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- dv/pga_ctrl_tb.sv
/*
 * Testbench for the PGA gain controller. Drives host commands, models the
 * gain register, decodes each serial frame and checks codes and errors.
 */
module pga_ctrl_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int GAIN_MAX    = 200;
  localparam int N_DIRECTED  = 21;
  localparam int N_RAND      = 64;
  localparam int CYCLE_LIMIT = 40 * (N_DIRECTED + N_RAND) + 200;

  logic       sck;
  logic       rst;
  logic       cmd_valid_i;
  logic [2:0] cmd_op_i;
  logic [7:0] cmd_arg_i;
  logic       cmd_ready_o;
  logic       cmd_err_o;
  logic [7:0] gain_o;
  logic       cs_n_o;
  logic       sck_o;
  logic       mosi_o;

  logic [7:0] exp_q[$];      // expected codes in command order.
  logic [7:0] model_gain;
  logic [7:0] frame_bits;
  logic [31:0] rnd_state;
  logic       in_frame;
  int         frame_len;
  int         sck_edges;
  int         frames;
  int         legal_cnt;
  int         err_exp;
  int         err_seen;
  int         errors;
  int         cycle_cnt;

  pga_ctrl_top #(
    .GAIN_MAX (GAIN_MAX)
  ) u_pga_ctrl_top (
    .sck         (sck),
    .rst         (rst),
    .cmd_valid_i (cmd_valid_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_arg_i   (cmd_arg_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_err_o   (cmd_err_o),
    .gain_o      (gain_o),
    .cs_n_o      (cs_n_o),
    .sck_o       (sck_o),
    .mosi_o      (mosi_o)
  );

  always #2 sck = ~sck;

  // ------------------------------------------------------------------------
  // Reference model and helpers
  // ------------------------------------------------------------------------
  function automatic logic [7:0] ref_gain(input logic [7:0] gain, input logic [2:0] op,
                                          input logic [7:0] arg);
    int g;
    int a;
    int r;
    g = int'(gain);
    a = int'(arg);
    case (op)
      pga_pkg::OP_SET: r = (a > GAIN_MAX) ? GAIN_MAX : a;
      pga_pkg::OP_INC: r = (g + a > GAIN_MAX) ? GAIN_MAX : g + a;
      pga_pkg::OP_DEC: r = (a > g) ? 0 : g - a;
      default:         r = g;                   // refresh keeps the gain.
    endcase
    return 8'(r);
  endfunction

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // called on a falling edge, returns on the falling edge after the transfer.
  task automatic send_cmd(input logic [2:0] op, input logic [7:0] arg);
    cmd_valid_i = 1'b1;
    cmd_op_i    = op;
    cmd_arg_i   = arg;
    while (!cmd_ready_o) @(negedge sck);       // ready only moves on rising edges.
    if (op < 3'd4) begin
      model_gain = ref_gain(model_gain, op, arg);
      exp_q.push_back(model_gain);
      legal_cnt++;
    end else begin
      err_exp++;
    end
    @(negedge sck);
  endtask

  task automatic pause_host(input int n);
    cmd_valid_i = 1'b0;
    repeat (n) @(negedge sck);
  endtask

  // waits until every expected frame has been seen, then lets error pulses land.
  task automatic wait_frames_done();
    pause_host(0);
    while (!(exp_q.size() == 0 && cs_n_o === 1'b1)) @(negedge sck);
    repeat (3) @(negedge sck);
  endtask

  task automatic check_gain();
    assert (gain_o == model_gain) else begin
      errors++;
      $display("ERROR gain_o: expected 0x%02h, actual 0x%02h", model_gain, gain_o);
    end
  endtask

  // ------------------------------------------------------------------------
  // Frame monitor and comparison
  // ------------------------------------------------------------------------
  always @(negedge sck) begin
    if (cs_n_o === 1'b0) begin
      frame_bits = {frame_bits[6:0], mosi_o};  // MSB arrives first.
      frame_len++;
      in_frame = 1'b1;
    end
    if (cmd_err_o === 1'b1) begin
      err_seen++;
    end
  end

  // every amplifier clock edge lies inside a frame.
  always @(posedge sck_o) begin
    sck_edges++;
    assert (cs_n_o === 1'b0) else begin
      errors++;
      $display("amplifier clock rose while chip select was high");
    end
  end

  always @(posedge cs_n_o) begin
    if (in_frame) begin
      frames++;
      assert (frame_len == 8) else begin
        errors++;
        $display("frame %0d carried %0d bits instead of 8", frames, frame_len);
      end
      assert (sck_edges == 8) else begin
        errors++;
        $display("frame %0d had %0d amplifier clock edges instead of 8", frames, sck_edges);
      end
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("frame 0x%02h arrived with no command waiting for it", frame_bits);
      end
      if (exp_q.size() != 0) begin
        assert (frame_bits == exp_q[0]) else begin
          errors++;
          $display("ERROR mosi_o: expected 0x%02h, actual 0x%02h", exp_q[0], frame_bits);
        end
        void'(exp_q.pop_front());
      end
      frame_len = 0;
      sck_edges = 0;
      in_frame  = 1'b0;
    end
  end

  always @(posedge sck) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d frames still expected", cycle_cnt,
               exp_q.size());
      $display("frames=%0d legal=%0d err_pulses=%0d err_expected=%0d errors=%0d",
               frames, legal_cnt, err_seen, err_exp, errors);
      $display("Some tests failed");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  initial begin
    logic [2:0] op;
    logic [7:0] arg;
    int         frames_before;
    sck         = 1'b0;
    rst         = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_op_i    = 3'd0;
    cmd_arg_i   = 8'd0;
    model_gain  = 8'd0;
    frame_bits  = 8'd0;
    rnd_state   = 32'd94751;
    in_frame    = 1'b0;
    frame_len   = 0;
    sck_edges   = 0;
    frames      = 0;
    legal_cnt   = 0;
    err_exp     = 0;
    err_seen    = 0;
    errors      = 0;
    cycle_cnt   = 0;
    repeat (2) @(posedge sck);
    @(negedge sck);
    rst = 1'b0;
    @(negedge sck);

    // idle state right after reset.
    assert (cs_n_o === 1'b1 && sck_o === 1'b0 && gain_o === 8'd0 && cmd_ready_o === 1'b1)
      else begin
        errors++;
        $display("ERROR reset state: cs_n_o=0x%h sck_o=0x%h gain_o=0x%02h cmd_ready_o=0x%h",
                 cs_n_o, sck_o, gain_o, cmd_ready_o);
      end

    // set below and above the ceiling.
    send_cmd(pga_pkg::OP_SET, 8'd77);
    wait_frames_done();
    check_gain();
    send_cmd(pga_pkg::OP_SET, 8'd250);
    wait_frames_done();
    check_gain();
    send_cmd(pga_pkg::OP_SET, 8'd200);
    wait_frames_done();
    check_gain();

    // step chains into both limits.
    send_cmd(pga_pkg::OP_SET, 8'd180);
    repeat (4) send_cmd(pga_pkg::OP_INC, 8'd7);
    wait_frames_done();
    check_gain();
    repeat (4) send_cmd(pga_pkg::OP_DEC, 8'd60);
    wait_frames_done();
    check_gain();
    send_cmd(pga_pkg::OP_INC, 8'd255);
    send_cmd(pga_pkg::OP_DEC, 8'd255);
    wait_frames_done();
    check_gain();

    // refresh rewrites the same code.
    send_cmd(pga_pkg::OP_SET, 8'd123);
    send_cmd(pga_pkg::OP_REFRESH, 8'd9);
    send_cmd(pga_pkg::OP_REFRESH, 8'd0);
    wait_frames_done();
    check_gain();

    // illegal opcodes give no frame and no gain change.
    frames_before = frames;
    for (int k = 4; k < 8; k++) begin
      send_cmd(3'(k), 8'hA5);
    end
    wait_frames_done();
    check_gain();
    assert (frames == frames_before) else begin
      errors++;
      $display("illegal opcodes produced %0d frames", frames - frames_before);
    end

    // random commands, first half back to back, then with gaps.
    for (int i = 0; i < N_RAND; i++) begin
      rnd_state = next_rand(rnd_state);
      op  = rnd_state[2:0];
      arg = (op == 3'd1 || op == 3'd2) ? (rnd_state[15:8] >> 2) : rnd_state[15:8];
      send_cmd(op, arg);
      if (i >= N_RAND / 2) begin
        pause_host(int'(rnd_state[21:20]));
      end
    end
    wait_frames_done();
    check_gain();

    assert (frames == legal_cnt) else begin
      errors++;
      $display("saw %0d frames for %0d legal commands", frames, legal_cnt);
    end
    assert (err_seen == err_exp) else begin
      errors++;
      $display("saw %0d error pulses for %0d illegal commands", err_seen, err_exp);
    end

    $display("frames=%0d legal=%0d err_pulses=%0d err_expected=%0d errors=%0d",
             frames, legal_cnt, err_seen, err_exp, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- dv/pga_ctrl_chk.sv
/*
 * Frame protocol checker for the PGA serial writer, bound into the
 * writer. Checks chip-select length and the gap before the next code.
 */
module pga_ctrl_chk (
  input logic sck,
  input logic rst,
  input logic cs_n_o,
  input logic code_ready_o
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [3:0] low_cnt; // cycles of the current frame seen so far.

  always_ff @(posedge sck) begin
    if (rst) begin
      low_cnt <= 4'd0;
    end else if (!cs_n_o) begin
      low_cnt <= low_cnt + 4'd1;
    end else begin
      low_cnt <= 4'd0;
    end
  end

  // a frame that closes has run exactly 8 bits.
  frame_len_a: assert property (@(posedge sck) disable iff (rst)
    $rose(cs_n_o) |-> (low_cnt == 4'd8))
    else $error("chip select rose after %0d low cycles", low_cnt);

  // and never outlasts them.
  frame_max_a: assert property (@(posedge sck) disable iff (rst)
    !cs_n_o |-> (low_cnt < 4'd8))
    else $error("chip select held low past 8 cycles");

  // the writer spends a cycle with chip select high before it is ready again.
  ready_rise_a: assert property (@(posedge sck) disable iff (rst)
    $rose(code_ready_o) |-> $past(cs_n_o))
    else $error("writer became ready straight out of a frame");

endmodule

bind pga_spi_writer pga_ctrl_chk u_pga_ctrl_chk (
  .sck          (sck),
  .rst          (rst),
  .cs_n_o       (cs_n_o),
  .code_ready_o (code_ready_o)
);

//--- hdl/pga_ctrl_top.sv
/*
 * PGA gain controller top level. Chains the command decoder, the gain
 * execute stage and the serial writer.
 */
module pga_ctrl_top #(
  parameter int unsigned GAIN_MAX = pga_pkg::GAIN_MAX_DEF
) (
  input  logic                       sck,
  input  logic                       rst,
  input  logic                       cmd_valid_i,
  input  logic [2:0]                 cmd_op_i,
  input  logic [pga_pkg::CODE_W-1:0] cmd_arg_i,
  output logic                       cmd_ready_o,
  output logic                       cmd_err_o,
  output logic [pga_pkg::CODE_W-1:0] gain_o,
  output logic                       cs_n_o,
  output logic                       sck_o,
  output logic                       mosi_o
);

  logic                       code_valid;
  logic                       code_ready;
  logic [pga_pkg::CODE_W-1:0] code;

  gain_op_if u_op_if ();

  pga_cmd_decode u_cmd_decode (
    .sck         (sck),
    .rst         (rst),
    .cmd_valid_i (cmd_valid_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_arg_i   (cmd_arg_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_err_o   (cmd_err_o),
    .op_o        (u_op_if.src)
  );

  pga_gain_exec #(
    .GAIN_MAX (GAIN_MAX)
  ) u_gain_exec (
    .sck          (sck),
    .rst          (rst),
    .op_i         (u_op_if.dst),
    .code_valid_o (code_valid),
    .code_ready_i (code_ready),
    .code_o       (code),
    .gain_o       (gain_o)
  );

  pga_spi_writer u_spi_writer (
    .sck          (sck),
    .rst          (rst),
    .code_valid_i (code_valid),
    .code_i       (code),
    .code_ready_o (code_ready),
    .cs_n_o       (cs_n_o),
    .sck_o        (sck_o),
    .mosi_o       (mosi_o)
  );

endmodule

//--- hdl/pga_spi_writer.sv
/*
 * PGA serial writer. Shifts one gain code out MSB first inside a
 * chip-select frame, with a gated inverted clock for the amplifier.
 */
module pga_spi_writer (
  input  logic                       sck,
  input  logic                       rst,
  input  logic                       code_valid_i,
  input  logic [pga_pkg::CODE_W-1:0] code_i,
  output logic                       code_ready_o,
  output logic                       cs_n_o,
  output logic                       sck_o,
  output logic                       mosi_o
);

  typedef enum logic [1:0] {
    IDLE,   // waiting for a code.
    ACTIVE, // shifting the frame.
    WAIT    // gap before the next frame may start.
  } wr_state_e;

  wr_state_e                  state_q;
  wr_state_e                  state_nxt;
  logic [pga_pkg::CODE_W-1:0] shift_q;
  logic [2:0]                 bit_cnt_q;
  logic                       last_bit;
  logic                       code_take;

  assign code_ready_o = (state_q == IDLE);
  assign code_take    = code_valid_i && code_ready_o;
  assign last_bit     = (bit_cnt_q == 3'd7);

  // --------------------------------------------------------------------------
  // Frame FSM
  // --------------------------------------------------------------------------
  always_comb begin
    state_nxt = state_q;
    case (state_q)
      IDLE: begin
        if (code_take) begin
          state_nxt = ACTIVE;
        end
      end
      ACTIVE: begin
        if (last_bit) begin
          state_nxt = WAIT;
        end
      end
      WAIT: begin
        state_nxt = IDLE;             // one cycle with chip select high.
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge sck) begin
    if (rst) begin
      state_q   <= IDLE;
      bit_cnt_q <= 3'd0;
    end else begin
      state_q <= state_nxt;
      if (state_q == ACTIVE) begin
        bit_cnt_q <= bit_cnt_q + 3'd1;
      end else begin
        bit_cnt_q <= 3'd0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Data path
  // --------------------------------------------------------------------------
  always_ff @(posedge sck) begin
    if (code_take) begin
      shift_q <= code_i;
    end else if (state_q == ACTIVE) begin
      shift_q <= {shift_q[pga_pkg::CODE_W-2:0], 1'b0};
    end
  end

  // Data moves on the rising edge of sck, so the inverted clock rises at
  // mid-bit and the amplifier samples a settled value.
  assign sck_o  = (state_q == ACTIVE) && !sck;
  assign cs_n_o = (state_q != ACTIVE);
  assign mosi_o = shift_q[pga_pkg::CODE_W-1];

endmodule

//--- hdl/pga_gain_exec.sv
/*
 * PGA gain execute stage. Applies set, step and refresh operations to
 * the gain register with clamping and hands each result to the writer.
 */
module pga_gain_exec #(
  parameter int unsigned GAIN_MAX = pga_pkg::GAIN_MAX_DEF
) (
  input  logic                       sck,
  input  logic                       rst,
  gain_op_if.dst                     op_i,
  output logic                       code_valid_o,
  input  logic                       code_ready_i,
  output logic [pga_pkg::CODE_W-1:0] code_o,
  output logic [pga_pkg::CODE_W-1:0] gain_o
);

  localparam logic [pga_pkg::CODE_W-1:0] MAX_CODE = GAIN_MAX[pga_pkg::CODE_W-1:0];

  logic [pga_pkg::CODE_W-1:0] gain_q;
  logic [pga_pkg::CODE_W-1:0] gain_nxt;
  logic [pga_pkg::CODE_W-1:0] arg;
  logic [pga_pkg::CODE_W:0]   gain_sum;
  logic                       pend_q;
  logic                       op_take;

  // --------------------------------------------------------------------------
  // Operation handshake
  // --------------------------------------------------------------------------
  assign op_i.ready   = !pend_q;                    // one code in flight at most.
  assign op_take      = op_i.valid && op_i.ready;
  assign op_i.err_clr = op_take && op_i.last_err;   // a good operation ends the error.

  // --------------------------------------------------------------------------
  // Next gain with clamping
  // --------------------------------------------------------------------------
  assign arg      = op_i.op.arg;
  assign gain_sum = {1'b0, gain_q} + {1'b0, arg};   // carry bit catches wrap.

  always_comb begin
    gain_nxt = gain_q;
    case (op_i.op.kind)
      pga_pkg::OP_SET: begin
        gain_nxt = (arg > MAX_CODE) ? MAX_CODE : arg;
      end
      pga_pkg::OP_INC: begin
        if (gain_sum > {1'b0, MAX_CODE}) begin
          gain_nxt = MAX_CODE;                      // saturate at the ceiling.
        end else begin
          gain_nxt = gain_sum[pga_pkg::CODE_W-1:0];
        end
      end
      pga_pkg::OP_DEC: begin
        gain_nxt = (arg > gain_q) ? '0 : gain_q - arg;
      end
      default: begin
        gain_nxt = gain_q;                          // refresh rewrites the same code.
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // Gain register and pending code
  // --------------------------------------------------------------------------
  always_ff @(posedge sck) begin
    if (rst) begin
      gain_q <= '0;
      pend_q <= 1'b0;
    end else if (op_take) begin
      gain_q <= gain_nxt;
      pend_q <= 1'b1;                               // every result gets a frame.
    end else if (code_ready_i) begin
      pend_q <= 1'b0;
    end
  end

  // the gain cannot move while a code is pending, so the register is the code.
  assign code_o       = gain_q;
  assign code_valid_o = pend_q;
  assign gain_o       = gain_q;

endmodule

//--- hdl/pga_cmd_decode.sv
/*
 * PGA command decoder. Takes host commands, keeps legal ones in a
 * one-entry buffer and flags illegal opcodes with a one-cycle pulse.
 */
module pga_cmd_decode (
  input  logic                       sck,
  input  logic                       rst,
  input  logic                       cmd_valid_i,
  input  logic [2:0]                 cmd_op_i,
  input  logic [pga_pkg::CODE_W-1:0] cmd_arg_i,
  output logic                       cmd_ready_o,
  output logic                       cmd_err_o,
  gain_op_if.src                     op_o
);

  logic             buf_valid_q;
  pga_pkg::pga_op_t buf_op_q;
  logic             err_q;
  logic             last_err_q;
  logic             cmd_acc;
  logic             cmd_legal;
  logic             cmd_bad;
  logic             buf_drain;

  assign cmd_legal   = pga_pkg::op_is_legal(cmd_op_i);
  assign buf_drain   = buf_valid_q && op_o.ready;   // execute takes the entry.
  assign cmd_ready_o = !buf_valid_q || op_o.ready;  // room now or after this edge.
  assign cmd_acc     = cmd_valid_i && cmd_ready_o;
  assign cmd_bad     = cmd_acc && !cmd_legal;

  // --------------------------------------------------------------------------
  // One-entry buffer
  // --------------------------------------------------------------------------
  always_ff @(posedge sck) begin
    if (rst) begin
      buf_valid_q <= 1'b0;
    end else if (cmd_acc && cmd_legal) begin
      buf_valid_q <= 1'b1;                 // a refill wins over a drain.
    end else if (buf_drain) begin
      buf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge sck) begin
    if (cmd_acc && cmd_legal) begin
      buf_op_q.kind <= pga_pkg::pga_op_e'(cmd_op_i);
      buf_op_q.arg  <= cmd_arg_i;
    end
  end

  // --------------------------------------------------------------------------
  // Error reporting
  // --------------------------------------------------------------------------
  always_ff @(posedge sck) begin
    if (rst) begin
      err_q      <= 1'b0;
      last_err_q <= 1'b0;
    end else begin
      err_q <= cmd_bad;                    // one pulse per dropped command.
      if (cmd_bad) begin
        last_err_q <= 1'b1;
      end else if (op_o.err_clr) begin
        last_err_q <= 1'b0;
      end
    end
  end

  assign cmd_err_o     = err_q;
  assign op_o.valid    = buf_valid_q;
  assign op_o.op       = buf_op_q;
  assign op_o.last_err = last_err_q;

endmodule

//--- hdl/gain_op_if.sv
/*
 * Decoded-operation channel between the command decoder and the
 * gain execute stage, with a sticky error flag cleared by execute.
 */
interface gain_op_if;

  logic             valid;    // decoder holds a legal operation.
  logic             ready;    // execute can take an operation.
  pga_pkg::pga_op_t op;       // held stable while valid waits for ready.
  logic             last_err; // set by an illegal command, stays set.
  logic             err_clr;  // execute drops the sticky error.

  // decoder side.
  modport src (
    output valid,
    output op,
    output last_err,
    input  ready,
    input  err_clr
  );

  // execute side.
  modport dst (
    input  valid,
    input  op,
    input  last_err,
    output ready,
    output err_clr
  );

endinterface

//--- hdl/pga_pkg.sv
/*
 * PGA gain controller shared definitions: gain code width, command
 * opcodes and the decoded operation passed from decode to execute.
 */
package pga_pkg;

  // --------------------------------------------------------------------------
  // Gain code
  // --------------------------------------------------------------------------
  localparam int CODE_W       = 8;   // the amplifier frame carries 8 bits.
  localparam int GAIN_MAX_DEF = 200; // default ceiling of the gain register.

  // --------------------------------------------------------------------------
  // Command opcodes
  // --------------------------------------------------------------------------
  typedef enum logic [2:0] {
    OP_SET     = 3'd0, // load the operand as the new gain.
    OP_INC     = 3'd1, // add the operand.
    OP_DEC     = 3'd2, // subtract the operand.
    OP_REFRESH = 3'd3  // rewrite the current gain unchanged.
  } pga_op_e;

  // Codes 4 to 7 have no meaning and are dropped by the decoder.
  typedef struct packed {
    pga_op_e           kind;
    logic [CODE_W-1:0] arg;
  } pga_op_t;

  function automatic logic op_is_legal(logic [2:0] op);
    logic legal;
    case (op)
      OP_SET, OP_INC, OP_DEC, OP_REFRESH: legal = 1'b1;
      default: legal = 1'b0;
    endcase
    return legal;
  endfunction

endpackage
